/* hdl/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Physical byte address width
`define FETCH_PADDR_W 32

// One uncompressed RISC-V instruction
`define FETCH_INSTR_W 32

// Instruction memory depth in words, addresses wrap modulo this
`define FETCH_MEM_WORDS 256

`endif

/* hdl/fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    typedef logic [`FETCH_PADDR_W-1:0] t_paddr;

    // Major opcode field, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OP_LUI      = 7'b0110111,
        OP_AUIPC    = 7'b0010111,
        OP_JAL      = 7'b1101111,
        OP_BRANCH   = 7'b1100011,
        OP_LOAD     = 7'b0000011,
        OP_STORE    = 7'b0100011,
        OP_IMM      = 7'b0010011,
        OP_REG      = 7'b0110011,
        // Used as halt by the front end
        OP_MISC_MEM = 7'b0001111
    } t_rv_opcode;

    typedef struct packed {
        logic [`FETCH_INSTR_W-8:0] rest;
        t_rv_opcode                opcode;
    } t_rv_instr;

    // Front end to fetch buffer
    typedef struct packed {
        logic   valid;
        t_paddr addr;
    } t_fe_fb_req;

    // Fetch buffer back to front end
    typedef struct packed {
        logic      valid;
        t_rv_instr instr;
        t_paddr    pc;
    } t_fb_fe_rsp;

    // Packet handed to decode
    typedef struct packed {
        t_rv_instr instr;
        t_paddr    pc;
    } t_instr_pkt;

    typedef enum logic [2:0] {
        FE_IDLE,
        FE_REQ_IC,
        FE_PDG_IC,
        FE_PDG_STALL,
        FE_DRAIN,
        FE_HALT
    } t_fe_state;

endpackage

`default_nettype wire

/* hdl/fetch_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_buffer (
    input  logic                  clk,
    input  logic                  reset,

    input  fetch_pkg::t_fe_fb_req fb_req,
    output fetch_pkg::t_fb_fe_rsp fb_rsp,

    input  logic                  load_en,
    input  fetch_pkg::t_paddr     load_addr,
    input  fetch_pkg::t_rv_instr  load_data
);

    localparam int IDX_W = $clog2(`FETCH_MEM_WORDS);

    fetch_pkg::t_rv_instr mem [`FETCH_MEM_WORDS];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    logic                 rsp_valid;
    fetch_pkg::t_rv_instr rsp_instr;
    fetch_pkg::t_paddr    rsp_pc;

    // Word index, byte offset dropped and upper bits wrap
    assign rd_idx = fb_req.addr[IDX_W+1:2];
    assign wr_idx = load_addr[IDX_W+1:2];

    // Load port from the testbench
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_idx] <= load_data;
        end
    end

    // Read word and its address travel together
    always_ff @(posedge clk) begin
        if (fb_req.valid) begin
            rsp_instr <= mem[rd_idx];
            rsp_pc    <= fb_req.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fb_req.valid;
        end
    end

    always_comb begin
        fb_rsp.valid = rsp_valid;
        fb_rsp.instr = rsp_instr;
        fb_rsp.pc    = rsp_pc;
    end

    // No response without a request one cycle before
    a_rsp_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        !fb_req.valid |=> !fb_rsp.valid
    );

    // Loading only happens while fetch is quiet
    a_no_load_during_fetch: assert property (
        @(posedge clk) disable iff (reset)
        !(load_en && fb_req.valid)
    );

endmodule

`default_nettype wire

/* hdl/fe_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module fe_ctl (
    input  logic                clk,
    input  logic                reset,

    output fetch_pkg::t_fe_fb_req fb_req,
    input  fetch_pkg::t_fb_fe_rsp fb_rsp,

    input  fetch_pkg::t_paddr   br_tgt,
    input  logic                br_mispred,

    input  logic                stall,
    output logic                valid_fe,
    output fetch_pkg::t_instr_pkt instr_fe,
    output logic                halted
);

    fetch_pkg::t_fe_state  state;
    fetch_pkg::t_fe_state  state_nxt;
    fetch_pkg::t_paddr     pc;
    fetch_pkg::t_instr_pkt cap_pkt;

    logic rsp_live;
    logic halt_op;
    logic halt_hit;
    logic redirect;
    logic terminal;

    // Response that belongs to the current fetch stream
    assign rsp_live = (state == fetch_pkg::FE_PDG_IC) & fb_rsp.valid;
    assign halt_op  = fb_rsp.instr.opcode == fetch_pkg::OP_MISC_MEM;

    // Once the halt word is seen, redirects no longer apply
    assign terminal = (state == fetch_pkg::FE_DRAIN) | (state == fetch_pkg::FE_HALT);
    assign redirect = br_mispred & ~terminal;
    assign halt_hit = rsp_live & halt_op & ~redirect;

    always_comb begin
        state_nxt = state;
        case (state)
            fetch_pkg::FE_IDLE: begin
                state_nxt = fetch_pkg::FE_REQ_IC;
            end
            fetch_pkg::FE_REQ_IC: begin
                state_nxt = fetch_pkg::FE_PDG_IC;
            end
            fetch_pkg::FE_PDG_IC: begin
                if (halt_hit) begin
                    state_nxt = fetch_pkg::FE_DRAIN;
                end else if (rsp_live & stall) begin
                    // Park the word until decode takes it
                    state_nxt = fetch_pkg::FE_PDG_STALL;
                end
            end
            fetch_pkg::FE_PDG_STALL: begin
                if (!stall) begin
                    state_nxt = fetch_pkg::FE_PDG_IC;
                end
            end
            fetch_pkg::FE_DRAIN: begin
                if (!stall) begin
                    state_nxt = fetch_pkg::FE_HALT;
                end
            end
            fetch_pkg::FE_HALT: begin
                state_nxt = fetch_pkg::FE_HALT;
            end
            default: begin
                state_nxt = fetch_pkg::FE_IDLE;
            end
        endcase
        if (redirect) begin
            state_nxt = fetch_pkg::FE_REQ_IC;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch_pkg::FE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // At most one request in flight to the fetch buffer
    always_comb begin
        fb_req.addr  = pc;
        fb_req.valid = ~br_mispred
                     & ( (state == fetch_pkg::FE_REQ_IC)
                       | (rsp_live & ~stall & ~halt_op)
                       | ((state == fetch_pkg::FE_PDG_STALL) & ~stall));
    end

    // PC advances with each issued request
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= br_tgt;
        end else if (fb_req.valid) begin
            pc <= pc + 4;
        end
    end

    // Hold a stalled response for later delivery
    always_ff @(posedge clk) begin
        if (rsp_live) begin
            cap_pkt.instr <= fb_rsp.instr;
            cap_pkt.pc    <= fb_rsp.pc;
        end
    end

    always_comb begin
        valid_fe = ((rsp_live & ~halt_op) | (state == fetch_pkg::FE_PDG_STALL)) & ~redirect;
        if (state == fetch_pkg::FE_PDG_STALL) begin
            instr_fe = cap_pkt;
        end else begin
            instr_fe.instr = fb_rsp.instr;
            instr_fe.pc    = fb_rsp.pc;
        end
    end

    assign halted = state == fetch_pkg::FE_HALT;

    // Stalled delivery holds until decode takes it or a redirect flushes it
    a_hold_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        valid_fe && stall |=> br_mispred || (valid_fe && $stable(instr_fe))
    );

    // Halted front end is quiet on both request and response
    a_no_req_when_halted: assert property (
        @(posedge clk) disable iff (reset)
        state == fetch_pkg::FE_HALT |-> !fb_req.valid && !fb_rsp.valid
    );

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
    input  logic                  clk,
    input  logic                  reset,

    // Program load
    input  logic                  load_en,
    input  fetch_pkg::t_paddr     load_addr,
    input  fetch_pkg::t_rv_instr  load_data,

    // Redirect from the branch unit
    input  fetch_pkg::t_paddr     br_tgt,
    input  logic                  br_mispred,

    // Decode side
    input  logic                  stall,
    output logic                  valid_fe,
    output fetch_pkg::t_instr_pkt instr_fe,
    output logic                  halted
);

    fetch_pkg::t_fe_fb_req fb_req;
    fetch_pkg::t_fb_fe_rsp fb_rsp;

    fe_ctl i_fe_ctl (
        .clk        (clk),
        .reset      (reset),
        .fb_req     (fb_req),
        .fb_rsp     (fb_rsp),
        .br_tgt     (br_tgt),
        .br_mispred (br_mispred),
        .stall      (stall),
        .valid_fe   (valid_fe),
        .instr_fe   (instr_fe),
        .halted     (halted)
    );

    fetch_buffer i_fetch_buffer (
        .clk       (clk),
        .reset     (reset),
        .fb_req    (fb_req),
        .fb_rsp    (fb_rsp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

/* bench/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

    localparam int RESET_CYCLES = 16;
    localparam int IMAGE_WORDS  = 16;
    // Two halt words, the second one only reachable through a redirect
    localparam int HALT_A       = 10;
    localparam int HALT_B       = 15;
    localparam int N_ROWS       = 7;
    localparam int RUN_LIMIT    = 400;
    localparam int AFTER_HALT   = 8;

    typedef struct packed {
        logic              pulse_en;
        logic [15:0]       pulse_cycle;
        fetch_pkg::t_paddr tgt;
        logic [3:0]        density;
    } t_row;

    logic                  clk;
    logic                  reset;
    logic                  load_en;
    fetch_pkg::t_paddr     load_addr;
    fetch_pkg::t_rv_instr  load_data;
    fetch_pkg::t_paddr     br_tgt;
    logic                  br_mispred;
    logic                  stall;
    logic                  valid_fe;
    fetch_pkg::t_instr_pkt instr_fe;
    logic                  halted;

    t_row        rows [N_ROWS];
    logic [31:0] lfsr_state;
    int          value_errors;
    int          timeouts;

    fetch_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .br_tgt     (br_tgt),
        .br_mispred (br_mispred),
        .stall      (stall),
        .valid_fe   (valid_fe),
        .instr_fe   (instr_fe),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Program image, word contents mixed from the index
    function automatic fetch_pkg::t_rv_instr image_word(input int unsigned idx);
        fetch_pkg::t_rv_instr w;
        logic [31:0]          mix;
        mix    = idx * 32'h9e3779b1 + 32'h01234567;
        w.rest = mix[31:7];
        case (idx % 8)
            0:       w.opcode = fetch_pkg::OP_IMM;
            1:       w.opcode = fetch_pkg::OP_REG;
            2:       w.opcode = fetch_pkg::OP_LOAD;
            3:       w.opcode = fetch_pkg::OP_STORE;
            4:       w.opcode = fetch_pkg::OP_LUI;
            5:       w.opcode = fetch_pkg::OP_AUIPC;
            6:       w.opcode = fetch_pkg::OP_JAL;
            default: w.opcode = fetch_pkg::OP_BRANCH;
        endcase
        if (idx == HALT_A || idx == HALT_B) begin
            w.opcode = fetch_pkg::OP_MISC_MEM;
        end
        return w;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // Three LFSR bits per cycle, stall when below density out of 8
    function automatic logic draw_stall(input logic [3:0] density);
        logic [2:0] v;
        for (int i = 0; i < 3; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return {1'b0, v} < density;
    endfunction

    task automatic check_pkt(input fetch_pkg::t_instr_pkt got,
                             input fetch_pkg::t_instr_pkt exp,
                             input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s packet pc %h instr %h, expected pc %h instr %h",
                     $time, what, got.pc, got.instr, exp.pc, exp.instr);
        end
    endtask

    task automatic check_halted(input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: halted is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: valid_fe is %b in %s, expected %b", $time, got, what, exp);
        end
    endtask

    // Columns: pulse enable, pulse cycle, redirect target, stall density in eighths
    task automatic fill_table();
        rows[0] = '{1'b0, 16'd0, 32'h0000_0000, 4'd0};
        rows[1] = '{1'b0, 16'd0, 32'h0000_0000, 4'd4};
        rows[2] = '{1'b1, 16'd5, 32'h0000_002c, 4'd0};
        rows[3] = '{1'b1, 16'd8, 32'h0000_0010, 4'd3};
        rows[4] = '{1'b1, 16'd4, 32'h0000_0028, 4'd2};
        rows[5] = '{1'b1, 16'd9, 32'h0000_0030, 4'd6};
        rows[6] = '{1'b1, 16'd1, 32'h0000_0008, 4'd4};
    endtask

    // Program goes in through the load port while reset is high
    task automatic reset_and_load();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            reset      <= 1'b1;
            br_mispred <= 1'b0;
            stall      <= 1'b0;
            load_en    <= (i < IMAGE_WORDS);
            load_addr  <= fetch_pkg::t_paddr'(i * 4);
            load_data  <= image_word(i);
        end
    endtask

    task automatic run_row(input int r);
        t_row                  row;
        fetch_pkg::t_paddr     exp_pc;
        fetch_pkg::t_instr_pkt exp_pkt;
        fetch_pkg::t_instr_pkt held_pkt;
        fetch_pkg::t_rv_instr  last_word;
        logic                  held;
        logic                  done;
        int                    cycle;
        int                    delivered;
        row       = rows[r];
        exp_pc    = '0;
        held_pkt  = '0;
        held      = 1'b0;
        done      = 1'b0;
        cycle     = 0;
        delivered = 0;
        reset_and_load();
        while (!done && cycle < RUN_LIMIT) begin
            @(posedge clk);
            reset      <= 1'b0;
            load_en    <= 1'b0;
            stall      <= draw_stall(row.density);
            br_mispred <= row.pulse_en && (cycle == row.pulse_cycle);
            br_tgt     <= row.tgt;
            @(negedge clk);
            if (cycle == 0) begin
                check_halted(halted, 1'b0);
            end
            // A stalled packet must come back unchanged
            if (held && !br_mispred) begin
                check_valid(valid_fe, 1'b1, "stall hold");
                check_pkt(instr_fe, held_pkt, "held");
            end
            if (br_mispred) begin
                check_valid(valid_fe, 1'b0, "mispredict cycle");
                exp_pc = br_tgt;
            end else if (valid_fe && !stall) begin
                exp_pkt.instr = image_word(exp_pc >> 2);
                exp_pkt.pc    = exp_pc;
                if (exp_pkt.instr.opcode == fetch_pkg::OP_MISC_MEM) begin
                    value_errors++;
                    $display("[ERROR] %0t: halt word at pc %h was delivered", $time, exp_pc);
                end
                check_pkt(instr_fe, exp_pkt, "delivered");
                exp_pc = exp_pc + 4;
                delivered++;
            end
            held     = valid_fe && stall;
            held_pkt = instr_fe;
            done     = halted;
            cycle++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout in row %0d: halted did not rise within %0d cycles", r, RUN_LIMIT);
        end else begin
            check_valid(valid_fe, 1'b0, "halt entry");
            last_word = image_word(exp_pc >> 2);
            if (last_word.opcode != fetch_pkg::OP_MISC_MEM) begin
                value_errors++;
                $display("[ERROR] %0t: halted with next pc %h not a halt word", $time, exp_pc);
            end
            for (int i = 0; i < AFTER_HALT; i++) begin
                @(posedge clk);
                stall      <= draw_stall(row.density);
                br_mispred <= 1'b0;
                @(negedge clk);
                check_valid(valid_fe, 1'b0, "halted state");
                check_halted(halted, 1'b1);
            end
        end
        $display("Row %0d: %0d packets delivered in %0d cycles", r, delivered, cycle);
    endtask

    initial begin
        reset        = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        br_tgt       = '0;
        br_mispred   = 1'b0;
        stall        = 1'b0;
        lfsr_state   = 32'ha8ff4845;
        value_errors = 0;
        timeouts     = 0;
        fill_table();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("Done: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_buffer.sv
hdl/fe_ctl.sv
hdl/fetch_top.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_buffer.sv
      - hdl/fe_ctl.sv
      - hdl/fetch_top.sv
  - target: simulation
    files:
      - bench/fetch_tb.sv
